// ==== design/cart_pkg.sv ====
package cart_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    // {addr_hi, addr_lo[3:0]}
    typedef logic [7:0]  reg_addr_t;
    typedef logic [9:0]  bank_t;
    typedef logic [8:0]  rom_ext_t;
    typedef logic [3:0]  ram_ext_t;

    typedef enum logic [2:0] {
        wait_aa,
        wait_55,
        cmd,
        fast_mode,
        fast_write,
        single_write,
        erase
    } flash_state_t;

    // first generation bank registers
    localparam reg_addr_t reg_linear_off   = 8'hC0;
    localparam reg_addr_t reg_ram_bank     = 8'hC1;
    localparam reg_addr_t reg_rom_bank0    = 8'hC2;
    localparam reg_addr_t reg_rom_bank1    = 8'hC3;

    // second generation registers need the 2003 extension for writes
    localparam reg_addr_t reg_memory_ctrl  = 8'hCE;
    localparam reg_addr_t reg_ram_bank_l   = 8'hD0;
    localparam reg_addr_t reg_ram_bank_h   = 8'hD1;
    localparam reg_addr_t reg_rom_bank0_l  = 8'hD2;
    localparam reg_addr_t reg_rom_bank0_h  = 8'hD3;
    localparam reg_addr_t reg_rom_bank1_l  = 8'hD4;
    localparam reg_addr_t reg_rom_bank1_h  = 8'hD5;

    // cartridge extension registers
    localparam reg_addr_t reg_pow_cnt      = 8'hE2;
    localparam reg_addr_t reg_bank_mask_lo = 8'hE4;
    localparam reg_addr_t reg_bank_mask_hi = 8'hE5;
    localparam reg_addr_t reg_emu_cnt      = 8'hE6;

    // power control accepts this byte even when locked
    localparam byte_t pow_unlock_key = 8'hDD;

    localparam bank_t bank_reset = 10'h3FF;

    // flash command bytes
    localparam byte_t cmd_unlock1   = 8'hAA;
    localparam byte_t cmd_unlock2   = 8'h55;
    localparam byte_t cmd_fast      = 8'h20;
    localparam byte_t cmd_program   = 8'hA0;
    localparam byte_t cmd_erase_a   = 8'h10;
    localparam byte_t cmd_erase_b   = 8'h30;
    localparam byte_t cmd_fast_exit = 8'h90;

endpackage

// ==== design/mapper_regs.sv ====
`timescale 1ns/1ps

module mapper_regs import cart_pkg::*; (
    input  logic       SClk,
    input  logic       reset,
    input  logic       n_sel,
    input  logic       n_io,
    input  logic       n_oe,
    input  logic       n_we,
    input  logic [3:0] addr_lo,
    input  logic [3:0] addr_hi,
    input  byte_t      data_in,
    output logic       write_commit,
    output bank_t      ram_bank,
    output bank_t      rom0_bank,
    output bank_t      rom1_bank,
    output byte_t      linear_off,
    output rom_ext_t   rom_mask,
    output ram_ext_t   ram_mask,
    output logic       mask_rom0,
    output logic       mask_rom1,
    output logic       mask_ram,
    output logic       self_flash,
    output logic       enable_sram,
    output logic       enable_flash_emu,
    output logic       rom_8bit_bus,
    output byte_t      reg_data,
    output logic       reg_ack
);

    logic      n_we_s;
    logic      n_we_p;
    logic      io_access;
    logic      io_write;
    logic      ext_2003;
    logic      ext_nile;
    reg_addr_t reg_addr;
    byte_t     pow_cnt;
    byte_t     emu_cnt;

    assign io_access = ~n_sel & ~n_io;
    assign reg_addr  = {addr_hi, addr_lo};

    // write strobe seen low on one edge and high on the next
    always_ff @(posedge SClk) begin
        if (reset) begin
            n_we_s <= 1'b1;
            n_we_p <= 1'b1;
        end else begin
            n_we_s <= n_we;
            n_we_p <= n_we_s;
        end
    end

    assign write_commit = n_we_s & ~n_we_p;
    assign io_write     = write_commit & io_access;

    always_ff @(posedge SClk) begin
        if (reset) begin
            ram_bank         <= bank_reset;
            rom0_bank        <= bank_reset;
            rom1_bank        <= bank_reset;
            linear_off       <= 8'hFF;
            rom_mask         <= 9'h1FF;
            ram_mask         <= 4'hF;
            mask_rom0        <= 1'b1;
            mask_rom1        <= 1'b1;
            mask_ram         <= 1'b1;
            self_flash       <= 1'b0;
            ext_nile         <= 1'b1;
            ext_2003         <= 1'b1;
            enable_sram      <= 1'b1;
            enable_flash_emu <= 1'b0;
            rom_8bit_bus     <= 1'b0;
        end else if (io_write) begin
            case (reg_addr)
                reg_linear_off:  linear_off     <= data_in;
                reg_ram_bank:    ram_bank[7:0]  <= data_in;
                reg_rom_bank0:   rom0_bank[7:0] <= data_in;
                reg_rom_bank1:   rom1_bank[7:0] <= data_in;
                reg_ram_bank_l:  if (ext_2003) ram_bank[7:0]  <= data_in;
                reg_rom_bank0_l: if (ext_2003) rom0_bank[7:0] <= data_in;
                reg_rom_bank1_l: if (ext_2003) rom1_bank[7:0] <= data_in;
                reg_ram_bank_h:  if (ext_2003) ram_bank[9:8]  <= data_in[1:0];
                reg_rom_bank0_h: if (ext_2003) rom0_bank[9:8] <= data_in[1:0];
                reg_rom_bank1_h: if (ext_2003) rom1_bank[9:8] <= data_in[1:0];
                reg_memory_ctrl: if (ext_2003) self_flash     <= data_in[0];
                reg_bank_mask_lo: if (ext_nile) rom_mask[7:0] <= data_in;
                reg_bank_mask_hi: begin
                    if (ext_nile) begin
                        rom_mask[8] <= data_in[0];
                        mask_rom0   <= data_in[1];
                        mask_rom1   <= data_in[2];
                        mask_ram    <= data_in[3];
                        ram_mask    <= data_in[7:4];
                    end
                end
                reg_pow_cnt: begin
                    // the key byte reopens a locked register
                    if (ext_nile || data_in == pow_unlock_key) begin
                        ext_nile    <= data_in[2];
                        ext_2003    <= data_in[4];
                        enable_sram <= data_in[6];
                    end
                end
                reg_emu_cnt: begin
                    if (ext_nile) begin
                        enable_flash_emu <= data_in[2];
                        rom_8bit_bus     <= data_in[3];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign pow_cnt = {1'b0, enable_sram, 1'b0, ext_2003, 1'b0, ext_nile, 2'b00};
    assign emu_cnt = {4'h0, rom_8bit_bus, enable_flash_emu, 2'b00};

    always_comb begin
        reg_data = 8'h00;
        reg_ack  = io_access & ~n_oe;
        case (reg_addr)
            reg_linear_off:   reg_data = linear_off;
            reg_ram_bank:     reg_data = ram_bank[7:0];
            reg_rom_bank0:    reg_data = rom0_bank[7:0];
            reg_rom_bank1:    reg_data = rom1_bank[7:0];
            reg_ram_bank_l:   reg_data = ram_bank[7:0];
            reg_rom_bank0_l:  reg_data = rom0_bank[7:0];
            reg_rom_bank1_l:  reg_data = rom1_bank[7:0];
            reg_ram_bank_h:   reg_data = {6'h00, ram_bank[9:8]};
            reg_rom_bank0_h:  reg_data = {6'h00, rom0_bank[9:8]};
            reg_rom_bank1_h:  reg_data = {6'h00, rom1_bank[9:8]};
            reg_memory_ctrl:  reg_data = {7'h00, self_flash};
            reg_bank_mask_lo: reg_data = rom_mask[7:0];
            reg_bank_mask_hi: reg_data = {ram_mask, mask_ram, mask_rom1, mask_rom0, rom_mask[8]};
            reg_pow_cnt:      reg_data = pow_cnt;
            reg_emu_cnt:      reg_data = emu_cnt;
            default:          reg_ack  = 1'b0;
        endcase
    end

endmodule

// ==== design/bank_decode.sv ====
`timescale 1ns/1ps

module bank_decode import cart_pkg::*; (
    input  logic       n_sel,
    input  logic       n_io,
    input  logic       n_oe,
    input  logic       n_we,
    input  logic [3:0] addr_hi,
    input  bank_t      ram_bank,
    input  bank_t      rom0_bank,
    input  bank_t      rom1_bank,
    input  byte_t      linear_off,
    input  rom_ext_t   rom_mask,
    input  ram_ext_t   ram_mask,
    input  logic       mask_rom0,
    input  logic       mask_rom1,
    input  logic       mask_ram,
    input  logic       self_flash,
    input  logic       enable_sram,
    input  logic       pass_read,
    input  logic       pass_write,
    output logic [6:0] addr_ext,
    output logic       psram_hit,
    output logic       ram_area,
    output logic       any_psram_sel,
    output logic       n_psram1_sel,
    output logic       n_psram2_sel,
    output logic       n_sram_sel
);

    logic     sel_rom;
    logic     sel_ram;
    logic     apply_mask;
    rom_ext_t rom_pick;
    rom_ext_t rom_masked;
    ram_ext_t ram_masked;
    logic     mem_access;
    logic     psram1_addr;
    logic     psram2_addr;
    logic     sram_addr;
    logic     psram_pre;

    // window selection by the top address nibble
    always_comb begin
        sel_rom    = 1'b0;
        sel_ram    = 1'b0;
        apply_mask = 1'b1;
        rom_pick   = '0;
        case (addr_hi)
            4'h0: begin
            end
            4'h1: begin
                // self flash maps the RAM window onto ROM space
                sel_rom    = self_flash;
                sel_ram    = ~self_flash;
                rom_pick   = ram_bank[8:0];
                apply_mask = mask_ram;
            end
            4'h2: begin
                sel_rom    = 1'b1;
                rom_pick   = rom0_bank[8:0];
                apply_mask = mask_rom0;
            end
            4'h3: begin
                sel_rom    = 1'b1;
                rom_pick   = rom1_bank[8:0];
                apply_mask = mask_rom1;
            end
            default: begin
                sel_rom  = 1'b1;
                rom_pick = {linear_off[4:0], addr_hi};
            end
        endcase
    end

    assign rom_masked = apply_mask ? (rom_pick & rom_mask) : rom_pick;
    assign ram_masked = apply_mask ? (ram_bank[3:0] & ram_mask) : ram_bank[3:0];

    assign ram_area   = (addr_hi == 4'h1);
    assign mem_access = ~n_sel & n_io;

    assign psram1_addr = sel_rom && rom_masked[8:7] == 2'd0;
    assign psram2_addr = sel_rom && rom_masked[8:7] == 2'd1;
    assign sram_addr   = sel_ram && !ram_masked[3] && enable_sram;

    assign psram_hit = mem_access & (psram1_addr | psram2_addr);

    // SRAM only decodes the low three bank bits
    assign addr_ext[2:0] = sel_rom ? rom_masked[2:0] : ram_masked[2:0];
    assign addr_ext[6:3] = rom_masked[6:3];

    assign psram_pre = mem_access & ((~n_oe & pass_read) | (~n_we & pass_write));

    assign n_psram1_sel  = ~(psram_pre & psram1_addr);
    assign n_psram2_sel  = ~(psram_pre & psram2_addr);
    assign any_psram_sel = ~n_psram1_sel | ~n_psram2_sel;
    assign n_sram_sel    = ~(mem_access & sram_addr & (~n_oe | ~n_we));

endmodule

// ==== design/flash_emu.sv ====
`timescale 1ns/1ps

module flash_emu import cart_pkg::*; (
    input  logic  SClk,
    input  logic  reset,
    input  logic  write_commit,
    input  byte_t data_in,
    input  logic  psram_hit,
    input  logic  ram_area,
    input  logic  enable_flash_emu,
    output logic  pass_read,
    output logic  pass_write,
    output logic  catch_read,
    output byte_t catch_value
);

    flash_state_t state;
    logic         emu_active;

    // steps on every committed write that lands in PSRAM
    always_ff @(posedge SClk) begin
        if (reset) begin
            state <= wait_aa;
        end else if (write_commit && psram_hit) begin
            case (state)
                wait_aa: begin
                    if (data_in == cmd_unlock1) begin
                        state <= wait_55;
                    end
                end
                wait_55: begin
                    if (data_in == cmd_unlock2) begin
                        state <= cmd;
                    end else begin
                        state <= wait_aa;
                    end
                end
                cmd: begin
                    case (data_in)
                        cmd_fast:                 state <= fast_mode;
                        cmd_program:              state <= single_write;
                        cmd_erase_a, cmd_erase_b: state <= erase;
                        default:                  state <= wait_aa;
                    endcase
                end
                fast_mode: begin
                    if (data_in == cmd_program) begin
                        state <= fast_write;
                    end else if (data_in == cmd_fast_exit) begin
                        state <= wait_aa;
                    end
                end
                // the data write itself
                fast_write: state <= fast_mode;
                single_write: state <= wait_aa;
                erase: begin
                    if (data_in == cmd_unlock1) begin
                        state <= wait_55;
                    end else begin
                        state <= wait_aa;
                    end
                end
                default: state <= wait_aa;
            endcase
        end
    end

    assign emu_active = enable_flash_emu & ram_area;

    assign pass_read  = ~emu_active | (state != erase && state != fast_mode);
    assign pass_write = ~emu_active | (state == single_write || state == fast_write);

    // blocked reads are answered from here instead of PSRAM
    assign catch_read  = ~pass_read & psram_hit;
    assign catch_value = (state == erase) ? 8'hFF : 8'h00;

endmodule

// ==== design/data_out_mux.sv ====
`timescale 1ns/1ps

module data_out_mux import cart_pkg::*; (
    input  logic  n_sel,
    input  logic  n_oe,
    input  logic  n_we,
    input  logic  addr_lo0,
    input  word_t data_in,
    input  byte_t reg_data,
    input  logic  reg_ack,
    input  logic  catch_read,
    input  byte_t catch_value,
    input  logic  ram_area,
    input  logic  rom_8bit_bus,
    input  logic  any_psram_sel,
    output word_t data_out,
    output logic  data_oe_lo,
    output logic  data_oe_hi,
    output logic  psram_n_lb,
    output logic  psram_n_ub
);

    logic area_8bit;
    logic psram_hi_read;
    logic psram_hi_write;
    logic sel_oe;

    assign area_8bit  = ram_area | rom_8bit_bus;
    assign psram_n_lb = area_8bit & addr_lo0;
    assign psram_n_ub = area_8bit & ~addr_lo0;

    // odd bytes of an 8-bit area sit on the upper PSRAM lane
    assign psram_hi_read  = area_8bit & any_psram_sel & ~n_oe & addr_lo0;
    assign psram_hi_write = ram_area & any_psram_sel & ~n_we & addr_lo0;

    assign sel_oe = ~n_sel & ~n_oe;

    always_comb begin
        if (psram_hi_read) begin
            data_out[7:0] = data_in[15:8];
        end else if (reg_ack) begin
            data_out[7:0] = reg_data;
        end else begin
            data_out[7:0] = catch_value;
        end
    end

    assign data_out[15:8] = psram_hi_write ? data_in[7:0] : 8'h00;

    assign data_oe_lo = (sel_oe & (reg_ack | catch_read)) | psram_hi_read;
    assign data_oe_hi = ~n_sel & psram_hi_write;

endmodule

// ==== design/cart_mapper.sv ====
`timescale 1ns/1ps

module cart_mapper import cart_pkg::*; (
    input  logic       SClk,
    input  logic       reset,
    input  logic       n_sel,
    input  logic       n_oe,
    input  logic       n_we,
    input  logic       n_io,
    input  logic [8:0] addr_lo,
    input  logic [3:0] addr_hi,
    input  word_t      data_in,
    output word_t      data_out,
    output logic       data_oe_lo,
    output logic       data_oe_hi,
    output logic [6:0] addr_ext,
    output logic       n_mem_oe,
    output logic       n_mem_we,
    output logic       n_psram1_sel,
    output logic       n_psram2_sel,
    output logic       psram_n_lb,
    output logic       psram_n_ub,
    output logic       n_sram_sel
);

    logic     write_commit;
    bank_t    ram_bank;
    bank_t    rom0_bank;
    bank_t    rom1_bank;
    byte_t    linear_off;
    rom_ext_t rom_mask;
    ram_ext_t ram_mask;
    logic     mask_rom0;
    logic     mask_rom1;
    logic     mask_ram;
    logic     self_flash;
    logic     enable_sram;
    logic     enable_flash_emu;
    logic     rom_8bit_bus;
    byte_t    reg_data;
    logic     reg_ack;
    logic     psram_hit;
    logic     ram_area;
    logic     any_psram_sel;
    logic     pass_read;
    logic     pass_write;
    logic     catch_read;
    byte_t    catch_value;

    // memory strobes go to the chips unchanged
    assign n_mem_oe = n_oe;
    assign n_mem_we = n_we;

    mapper_regs u_regs (
        .SClk(SClk), .reset(reset),
        .n_sel(n_sel), .n_io(n_io), .n_oe(n_oe), .n_we(n_we),
        .addr_lo(addr_lo[3:0]), .addr_hi(addr_hi), .data_in(data_in[7:0]),
        .write_commit(write_commit),
        .ram_bank(ram_bank), .rom0_bank(rom0_bank), .rom1_bank(rom1_bank),
        .linear_off(linear_off), .rom_mask(rom_mask), .ram_mask(ram_mask),
        .mask_rom0(mask_rom0), .mask_rom1(mask_rom1), .mask_ram(mask_ram),
        .self_flash(self_flash), .enable_sram(enable_sram),
        .enable_flash_emu(enable_flash_emu), .rom_8bit_bus(rom_8bit_bus),
        .reg_data(reg_data), .reg_ack(reg_ack)
    );

    bank_decode u_decode (
        .n_sel(n_sel), .n_io(n_io), .n_oe(n_oe), .n_we(n_we), .addr_hi(addr_hi),
        .ram_bank(ram_bank), .rom0_bank(rom0_bank), .rom1_bank(rom1_bank),
        .linear_off(linear_off), .rom_mask(rom_mask), .ram_mask(ram_mask),
        .mask_rom0(mask_rom0), .mask_rom1(mask_rom1), .mask_ram(mask_ram),
        .self_flash(self_flash), .enable_sram(enable_sram),
        .pass_read(pass_read), .pass_write(pass_write),
        .addr_ext(addr_ext), .psram_hit(psram_hit), .ram_area(ram_area),
        .any_psram_sel(any_psram_sel), .n_psram1_sel(n_psram1_sel),
        .n_psram2_sel(n_psram2_sel), .n_sram_sel(n_sram_sel)
    );

    flash_emu u_flash (
        .SClk(SClk), .reset(reset), .write_commit(write_commit),
        .data_in(data_in[7:0]), .psram_hit(psram_hit), .ram_area(ram_area),
        .enable_flash_emu(enable_flash_emu),
        .pass_read(pass_read), .pass_write(pass_write),
        .catch_read(catch_read), .catch_value(catch_value)
    );

    data_out_mux u_dout (
        .n_sel(n_sel), .n_oe(n_oe), .n_we(n_we), .addr_lo0(addr_lo[0]),
        .data_in(data_in), .reg_data(reg_data), .reg_ack(reg_ack),
        .catch_read(catch_read), .catch_value(catch_value), .ram_area(ram_area),
        .rom_8bit_bus(rom_8bit_bus), .any_psram_sel(any_psram_sel),
        .data_out(data_out), .data_oe_lo(data_oe_lo), .data_oe_hi(data_oe_hi),
        .psram_n_lb(psram_n_lb), .psram_n_ub(psram_n_ub)
    );

endmodule

// ==== bench/cart_mapper_checker.sv ====
`timescale 1ns/1ps

module cart_mapper_checker (
    input logic SClk,
    input logic reset,
    input logic n_sel,
    input logic n_oe,
    input logic n_we,
    input logic n_psram1_sel,
    input logic n_psram2_sel,
    input logic n_sram_sel,
    input logic data_oe_lo
);

    // only one PSRAM chip may answer at a time
    psram_exclusive: assert property (@(posedge SClk) disable iff (reset)
        !(!n_psram1_sel && !n_psram2_sel))
        else $error("both PSRAM selects are active");

    // chips stay idle while the cartridge is not addressed
    idle_no_select: assert property (@(posedge SClk) disable iff (reset)
        n_sel |-> (n_psram1_sel && n_psram2_sel && n_sram_sel))
        else $error("chip select active while n_sel is high");

    // no strobe, no bus drive
    idle_no_drive: assert property (@(posedge SClk) disable iff (reset)
        (n_oe && n_we) |-> !data_oe_lo)
        else $error("data_oe_lo high without a bus strobe");

endmodule

bind cart_mapper cart_mapper_checker u_checker (
    .SClk(SClk), .reset(reset), .n_sel(n_sel), .n_oe(n_oe), .n_we(n_we),
    .n_psram1_sel(n_psram1_sel), .n_psram2_sel(n_psram2_sel),
    .n_sram_sel(n_sram_sel), .data_oe_lo(data_oe_lo)
);

// ==== bench/tb_cart_mapper.sv ====
`timescale 1ns/1ps

module tb_cart_mapper import cart_pkg::*; ();

    // the tests need about 600 cycles
    localparam int max_cycles = 2000;

    logic       SClk;
    logic       reset;
    logic       n_sel;
    logic       n_oe;
    logic       n_we;
    logic       n_io;
    logic [8:0] addr_lo;
    logic [3:0] addr_hi;
    word_t      data_in;
    word_t      data_out;
    logic       data_oe_lo;
    logic       data_oe_hi;
    logic [6:0] addr_ext;
    logic       n_mem_oe;
    logic       n_mem_we;
    logic       n_psram1_sel;
    logic       n_psram2_sel;
    logic       psram_n_lb;
    logic       psram_n_ub;
    logic       n_sram_sel;

    // outputs seen during the last access
    logic       got_p1;
    logic       got_p2;
    logic       got_sram;
    logic [6:0] got_ext;
    word_t      got_dout;
    logic       got_oe_lo;
    logic       got_oe_hi;
    logic       got_lb;
    logic       got_ub;
    logic       got_mem_oe;
    logic       got_mem_we;

    int          cycles;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;
    logic [31:0] rng;

    cart_mapper uut (
        .SClk(SClk), .reset(reset), .n_sel(n_sel), .n_oe(n_oe), .n_we(n_we),
        .n_io(n_io), .addr_lo(addr_lo), .addr_hi(addr_hi), .data_in(data_in),
        .data_out(data_out), .data_oe_lo(data_oe_lo), .data_oe_hi(data_oe_hi),
        .addr_ext(addr_ext), .n_mem_oe(n_mem_oe), .n_mem_we(n_mem_we),
        .n_psram1_sel(n_psram1_sel), .n_psram2_sel(n_psram2_sel),
        .psram_n_lb(psram_n_lb), .psram_n_ub(psram_n_ub), .n_sram_sel(n_sram_sel)
    );

    initial begin
        SClk = 1'b0;
        forever #50 SClk = ~SClk;
    end

    always @(posedge SClk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic apply_reset();
        @(negedge SClk);
        reset = 1'b1;
        repeat (8) @(negedge SClk);
        reset = 1'b0;
    endtask

    task automatic capture_outputs();
        got_p1     = n_psram1_sel;
        got_p2     = n_psram2_sel;
        got_sram   = n_sram_sel;
        got_ext    = addr_ext;
        got_dout   = data_out;
        got_oe_lo  = data_oe_lo;
        got_oe_hi  = data_oe_hi;
        got_lb     = psram_n_lb;
        got_ub     = psram_n_ub;
        got_mem_oe = n_mem_oe;
        got_mem_we = n_mem_we;
    endtask

    // n_we low for one cycle, bus held two cycles after it rises
    task automatic strobe_write(input logic io, input logic [3:0] hi,
                                input logic [8:0] lo, input word_t data);
        @(negedge SClk);
        n_sel   = 1'b0;
        n_io    = io;
        addr_hi = hi;
        addr_lo = lo;
        data_in = data;
        n_we    = 1'b0;
        @(negedge SClk);
        capture_outputs();
        n_we = 1'b1;
        repeat (2) @(negedge SClk);
        n_sel = 1'b1;
        n_io  = 1'b1;
    endtask

    task automatic strobe_read(input logic io, input logic [3:0] hi, input logic [8:0] lo);
        @(negedge SClk);
        n_sel   = 1'b0;
        n_io    = io;
        addr_hi = hi;
        addr_lo = lo;
        n_oe    = 1'b0;
        @(negedge SClk);
        capture_outputs();
        n_oe  = 1'b1;
        n_sel = 1'b1;
        n_io  = 1'b1;
    endtask

    task automatic io_write(input reg_addr_t addr, input byte_t data);
        strobe_write(1'b0, addr[7:4], {5'h00, addr[3:0]}, {8'h00, data});
    endtask

    task automatic io_read(input reg_addr_t addr);
        strobe_read(1'b0, addr[7:4], {5'h00, addr[3:0]});
    endtask

    task automatic mem_write(input logic [3:0] hi, input logic [8:0] lo, input word_t data);
        strobe_write(1'b1, hi, lo, data);
    endtask

    task automatic mem_read(input logic [3:0] hi, input logic [8:0] lo);
        strobe_read(1'b1, hi, lo);
    endtask

    task automatic check_reg(input string name, input reg_addr_t addr, input byte_t expected);
        io_read(addr);
        check_value(name, expected, got_dout[7:0]);
        check_value({name, " oe"}, 1'b1, got_oe_lo);
    endtask

    // selects and addr_ext for a window that maps to ROM space
    task automatic check_rom_window(input string name, input logic [3:0] hi,
                                    input rom_ext_t bank);
        mem_read(hi, 9'h000);
        check_value({name, " psram1"}, bank[8:7] != 2'd0, got_p1);
        check_value({name, " psram2"}, bank[8:7] != 2'd1, got_p2);
        check_value({name, " sram"}, 1'b1, got_sram);
        check_value({name, " addr_ext"}, bank[6:0], got_ext);
    endtask

    task automatic test_reset_readback();
        apply_reset();
        check_reg("reset pow_cnt", reg_pow_cnt, 8'h54);
        check_reg("reset mask_lo", reg_bank_mask_lo, 8'hFF);
        check_reg("reset ram_bank", reg_ram_bank, 8'hFF);
        check_reg("reset ram_bank_h", reg_ram_bank_h, 8'h03);
        finish_test("reset_readback");
    endtask

    task automatic test_bank_regs();
        apply_reset();
        io_write(reg_rom_bank0, 8'h5A);
        check_reg("bank rom0", reg_rom_bank0, 8'h5A);
        check_reg("bank rom0_l", reg_rom_bank0_l, 8'h5A);
        io_write(reg_rom_bank0_h, 8'h02);
        check_reg("bank rom0_h", reg_rom_bank0_h, 8'h02);
        io_write(reg_rom_bank1_l, 8'h33);
        check_reg("bank rom1", reg_rom_bank1, 8'h33);
        // drop the 2003 extension, keep nileswan and SRAM
        io_write(reg_pow_cnt, 8'h44);
        check_reg("bank pow_cnt", reg_pow_cnt, 8'h44);
        io_write(reg_rom_bank0_l, 8'h11);
        check_reg("bank locked rom0_l", reg_rom_bank0, 8'h5A);
        io_write(reg_rom_bank1_h, 8'h01);
        check_reg("bank locked rom1_h", reg_rom_bank1_h, 8'h03);
        io_write(reg_memory_ctrl, 8'h01);
        check_reg("bank locked mem_ctrl", reg_memory_ctrl, 8'h00);
        io_write(reg_rom_bank0, 8'h77);
        check_reg("bank gen1 rom0", reg_rom_bank0, 8'h77);
        finish_test("bank_regs");
    endtask

    task automatic test_translation();
        bank_t      ram_b;
        bank_t      rom0_b;
        bank_t      rom1_b;
        byte_t      lin;
        rom_ext_t   rmask;
        ram_ext_t   amask;
        logic [2:0] apply;
        logic [3:0] hi;
        rom_ext_t   bank;
        ram_ext_t   ram4;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            rng    = xorshift(rng);
            ram_b  = rng[9:0];
            rom0_b = rng[19:10];
            rom1_b = rng[29:20];
            rng    = xorshift(rng);
            lin    = rng[7:0];
            rmask  = rng[16:8];
            amask  = rng[20:17];
            apply  = rng[23:21];
            hi     = 4'h4 + rng[27:24] % 12;
            io_write(reg_linear_off, lin);
            io_write(reg_ram_bank, ram_b[7:0]);
            io_write(reg_ram_bank_h, {6'h00, ram_b[9:8]});
            io_write(reg_rom_bank0, rom0_b[7:0]);
            io_write(reg_rom_bank0_h, {6'h00, rom0_b[9:8]});
            io_write(reg_rom_bank1, rom1_b[7:0]);
            io_write(reg_rom_bank1_h, {6'h00, rom1_b[9:8]});
            io_write(reg_bank_mask_lo, rmask[7:0]);
            io_write(reg_bank_mask_hi, {amask, apply[2], apply[1], apply[0], rmask[8]});
            bank = apply[0] ? (rom0_b[8:0] & rmask) : rom0_b[8:0];
            check_rom_window($sformatf("xlate%0d rom0", i), 4'h2, bank);
            bank = apply[1] ? (rom1_b[8:0] & rmask) : rom1_b[8:0];
            check_rom_window($sformatf("xlate%0d rom1", i), 4'h3, bank);
            // linear area is masked regardless of apply bits
            bank = {lin[4:0], hi} & rmask;
            check_rom_window($sformatf("xlate%0d linear", i), hi, bank);
            ram4 = apply[2] ? (ram_b[3:0] & amask) : ram_b[3:0];
            mem_read(4'h1, 9'h000);
            check_value($sformatf("xlate%0d ram sram", i), ram4[3], got_sram);
            check_value($sformatf("xlate%0d ram psram1", i), 1'b1, got_p1);
            check_value($sformatf("xlate%0d ram psram2", i), 1'b1, got_p2);
            check_value($sformatf("xlate%0d ram addr_ext", i), ram4[2:0], got_ext[2:0]);
        end
        finish_test("translation");
    endtask

    task automatic test_pow_lock();
        apply_reset();
        io_write(reg_pow_cnt, 8'h50);
        check_reg("lock pow_cnt", reg_pow_cnt, 8'h50);
        io_write(reg_bank_mask_lo, 8'h0F);
        check_reg("lock mask_lo", reg_bank_mask_lo, 8'hFF);
        io_write(reg_pow_cnt, 8'h14);
        check_reg("lock no key", reg_pow_cnt, 8'h50);
        io_write(reg_pow_cnt, pow_unlock_key);
        check_reg("lock key", reg_pow_cnt, 8'h54);
        io_write(reg_bank_mask_lo, 8'h0F);
        check_reg("lock reopened mask_lo", reg_bank_mask_lo, 8'h0F);
        finish_test("pow_lock");
    endtask

    task automatic flash_command(input byte_t command);
        mem_write(4'h1, 9'h000, {8'h00, cmd_unlock1});
        mem_write(4'h1, 9'h000, {8'h00, cmd_unlock2});
        mem_write(4'h1, 9'h000, {8'h00, command});
    endtask

    // RAM window onto ROM bank 005, which sits in PSRAM 1
    task automatic map_ram_window();
        io_write(reg_ram_bank, 8'h05);
        io_write(reg_ram_bank_h, 8'h00);
        io_write(reg_memory_ctrl, 8'h01);
    endtask

    task automatic test_flash_emu();
        apply_reset();
        map_ram_window();
        io_write(reg_emu_cnt, 8'h04);
        mem_write(4'h1, 9'h000, 16'h0012);
        check_value("flash locked write", 1'b1, got_p1);
        flash_command(cmd_program);
        mem_write(4'h1, 9'h000, 16'h003C);
        check_value("flash program write", 1'b0, got_p1);
        mem_write(4'h1, 9'h000, 16'h003C);
        check_value("flash second write", 1'b1, got_p1);
        flash_command(cmd_erase_a);
        mem_read(4'h1, 9'h000);
        check_value("flash erase data", 8'hFF, got_dout[7:0]);
        check_value("flash erase oe", 1'b1, got_oe_lo);
        check_value("flash erase psram1", 1'b1, got_p1);
        finish_test("flash_emu");
    endtask

    task automatic test_byte_lanes();
        apply_reset();
        map_ram_window();
        mem_write(4'h1, 9'h001, 16'h00A5);
        check_value("lanes odd psram1", 1'b0, got_p1);
        check_value("lanes odd data hi", 8'hA5, got_dout[15:8]);
        check_value("lanes odd oe_hi", 1'b1, got_oe_hi);
        check_value("lanes odd lb", 1'b1, got_lb);
        check_value("lanes odd ub", 1'b0, got_ub);
        check_value("lanes write mem_we", 1'b0, got_mem_we);
        check_value("lanes write mem_oe", 1'b1, got_mem_oe);
        mem_write(4'h1, 9'h002, 16'h00A5);
        check_value("lanes even data hi", 8'h00, got_dout[15:8]);
        check_value("lanes even oe_hi", 1'b0, got_oe_hi);
        check_value("lanes even lb", 1'b0, got_lb);
        check_value("lanes even ub", 1'b1, got_ub);
        // odd read takes the upper PSRAM byte
        data_in = 16'h5AC3;
        mem_read(4'h1, 9'h001);
        check_value("lanes odd read data", 8'h5A, got_dout[7:0]);
        check_value("lanes odd read oe", 1'b1, got_oe_lo);
        check_value("lanes read mem_oe", 1'b0, got_mem_oe);
        check_value("lanes read mem_we", 1'b1, got_mem_we);
        finish_test("byte_lanes");
    endtask

    initial begin
        reset       = 1'b1;
        n_sel       = 1'b1;
        n_oe        = 1'b1;
        n_we        = 1'b1;
        n_io        = 1'b1;
        addr_lo     = 9'h000;
        addr_hi     = 4'h0;
        data_in     = 16'h0000;
        cycles      = 0;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests_run   = 0;
        rng         = 32'd79;
        test_reset_readback();
        test_bank_regs();
        test_translation();
        test_pow_lock();
        test_flash_emu();
        test_byte_lanes();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== cart_mapper.f ====
design/cart_pkg.sv
design/mapper_regs.sv
design/bank_decode.sv
design/flash_emu.sv
design/data_out_mux.sv
design/cart_mapper.sv
bench/cart_mapper_checker.sv
bench/tb_cart_mapper.sv
